// ==== filelist.f ====
source/UsiPkg.sv
source/GpioPkg.sv
source/SwInputSync.sv
source/SwitchFilter.sv
source/GpioCsr.sv
source/GpioSubsystem.sv
test/GpioSubsystem_props.sv
test/GpioSubsystemTb.sv

// ==== source/GpioCsr.sv ====
// GPIO control and status registers on the USI slave bus
module GpioCsr import UsiPkg::*; import GpioPkg::*; #(
	parameter int                         pBlockAdrsWidth = 8,
	parameter logic [pBlockAdrsWidth-1:0] pAdrsMap        = 1,
	parameter int                         pGpioWidth      = 5,
	parameter int                         pExtSwNum       = 7
)(
	input  logic                      iSCLK,
	input  logic                      iSRST,
	// Bus
	input  logic [cUsiBusWidth-1:0]   iSUsiAdrs,
	input  logic [cUsiBusWidth-1:0]   iSUsiWd,
	output logic [cUsiBusWidth-1:0]   oSUsiRd,
	// Status
	input  logic [pGpioWidth-1:0]     iGpioIn,
	input  logic [pExtSwNum-1:0]      iPushSw,
	input  logic [pExtSwNum-1:0]      iEdgeSw,
	input  logic [pExtSwNum-1:0]      iLongSw,
	input  logic                      iPllLock,
	output logic                      oEdgeClr,
	// Control
	output logic [pGpioWidth-1:0]     oGpioOutCtrl,
	output logic [pGpioWidth-1:0]     oGpioDir,
	output logic [pGpioWidth-1:0]     oGpioAltMode,
	output logic [cVideoOeWidth-1:0]  oVideoGpioOe,
	output logic [cAudioOeWidth-1:0]  oAudioGpioOe,
	output logic [cRomOeWidth-1:0]    oRomGpioOe,
	output logic [cCfgRomOeWidth-1:0] oCfgRomGpioOe
);

	UsiAccess                   qAccess;
	CsrOffset                   qOffset;
	logic [pBlockAdrsWidth-1:0] qBlock;
	logic                       qWrEn;

	// ------------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------------
	assign qAccess = UsiAccess'(iSUsiAdrs[cUsiWrBit]);
	assign qOffset = CsrOffset'(iSUsiAdrs[cCsrOffsetWidth-1:0]);
	assign qBlock  = iSUsiAdrs[cBlockLsb +: pBlockAdrsWidth];

	// Writes need the block match, reads only look at the offset
	assign qWrEn = (qAccess == UsiWrite) && (qBlock == pAdrsMap);

	// Press flags drop at the edge that captures the read word
	assign oEdgeClr = (qAccess == UsiRead) && (qOffset == RegEdgeSw);

	// ------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oGpioOutCtrl  <= {pGpioWidth{cGpioOutRstBit}};
			oGpioDir      <= {pGpioWidth{cGpioDirRstBit}};
			oGpioAltMode  <= {pGpioWidth{cGpioAltRstBit}};
			oVideoGpioOe  <= cVideoOeRst;
			oAudioGpioOe  <= cAudioOeRst;
			oRomGpioOe    <= cRomOeRst;
			oCfgRomGpioOe <= cCfgRomOeRst;
		end
		else if (qWrEn)
		begin
			case (qOffset)
				RegOutCtrl:
					oGpioOutCtrl <= iSUsiWd[pGpioWidth-1:0];
				RegDir:
					oGpioDir <= iSUsiWd[pGpioWidth-1:0];
				RegAltMode:
					oGpioAltMode <= iSUsiWd[pGpioWidth-1:0];
				RegVideoOe:
					oVideoGpioOe <= iSUsiWd[cVideoOeWidth-1:0];
				RegAudioOe:
					oAudioGpioOe <= iSUsiWd[cAudioOeWidth-1:0];
				RegRomOe:
					oRomGpioOe <= iSUsiWd[cRomOeWidth-1:0];
				RegCfgRomOe:
					oCfgRomGpioOe <= iSUsiWd[cCfgRomOeWidth-1:0];
				default:
				begin
					// Status offsets are read only
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Read mux, one cycle behind the address
	// Other offsets pass the write data on for the read chain
	// ------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oSUsiRd <= '0;
		else
		begin
			case (qOffset)
				RegOutCtrl:
					oSUsiRd <= cUsiBusWidth'(oGpioOutCtrl);
				RegDir:
					oSUsiRd <= cUsiBusWidth'(oGpioDir);
				RegAltMode:
					oSUsiRd <= cUsiBusWidth'(oGpioAltMode);
				RegVideoOe:
					oSUsiRd <= cUsiBusWidth'(oVideoGpioOe);
				RegAudioOe:
					oSUsiRd <= cUsiBusWidth'(oAudioGpioOe);
				RegRomOe:
					oSUsiRd <= cUsiBusWidth'(oRomGpioOe);
				RegCfgRomOe:
					oSUsiRd <= cUsiBusWidth'(oCfgRomGpioOe);
				RegGpioIn:
					oSUsiRd <= cUsiBusWidth'(iGpioIn);
				RegPushSw:
					oSUsiRd <= cUsiBusWidth'(iPushSw);
				RegEdgeSw:
					oSUsiRd <= cUsiBusWidth'(iEdgeSw);
				RegLongSw:
					oSUsiRd <= cUsiBusWidth'(iLongSw);
				RegPllLock:
					oSUsiRd <= cUsiBusWidth'(iPllLock);
				default:
					oSUsiRd <= iSUsiWd;
			endcase
		end
	end

endmodule

// ==== source/GpioPkg.sv ====
// GPIO block register map, switch filter states and reset values
package GpioPkg;

	// ------------------------------------------------------------------
	// Register offsets inside the GPIO block
	// ------------------------------------------------------------------
	typedef enum logic [7:0]
	{
		// Writable control registers
		RegOutCtrl  = 8'h00,
		RegDir      = 8'h04,
		RegAltMode  = 8'h08,
		RegVideoOe  = 8'h10,
		RegAudioOe  = 8'h14,
		RegRomOe    = 8'h18,
		RegCfgRomOe = 8'h1C,
		// Read-only status
		RegGpioIn   = 8'h40,
		RegPushSw   = 8'h41,
		RegEdgeSw   = 8'h42,
		RegLongSw   = 8'h43,
		RegPllLock  = 8'h44
	} CsrOffset;

	// Push switch filter states
	typedef enum logic [1:0]
	{
		SwIdle    = 2'd0,
		SwSettle  = 2'd1,
		SwPressed = 2'd2,
		SwHeld    = 2'd3
	} SwState;

	// ------------------------------------------------------------------
	// Pin group widths, fixed by the board
	// ------------------------------------------------------------------
	localparam int cVideoOeWidth  = 24;
	localparam int cAudioOeWidth  = 3;
	localparam int cRomOeWidth    = 8;
	localparam int cCfgRomOeWidth = 7;

	// Per-bit reset level of the general purpose registers
	// Pins come up as inputs in alternate mode, outputs low
	localparam logic cGpioOutRstBit = 1'b0;
	localparam logic cGpioDirRstBit = 1'b1;
	localparam logic cGpioAltRstBit = 1'b1;

	// Output enable masks come up disabled
	localparam logic [cVideoOeWidth-1:0]  cVideoOeRst  = '0;
	localparam logic [cAudioOeWidth-1:0]  cAudioOeRst  = '0;
	localparam logic [cRomOeWidth-1:0]    cRomOeRst    = '0;
	localparam logic [cCfgRomOeWidth-1:0] cCfgRomOeRst = '0;

endpackage

// ==== source/GpioSubsystem.sv ====
// GPIO subsystem top with input sync, per-switch filters and register file
module GpioSubsystem import UsiPkg::*; import GpioPkg::*; #(
	parameter int                         pBlockAdrsWidth = 8,
	parameter logic [pBlockAdrsWidth-1:0] pAdrsMap        = 1,
	parameter int                         pGpioWidth      = 5,
	parameter int                         pExtSwNum       = 7,
	parameter int                         pDebounceCycles = 20000,
	parameter int                         pLongCycles     = 2000000
)(
	input  logic                      iSCLK,
	input  logic                      iSRST,
	// Bus
	input  logic [cUsiBusWidth-1:0]   iSUsiAdrs,
	input  logic [cUsiBusWidth-1:0]   iSUsiWd,
	output logic [cUsiBusWidth-1:0]   oSUsiRd,
	// Pins
	input  logic [pGpioWidth-1:0]     iGpioIn,
	input  logic [pExtSwNum-1:0]      iSwRaw,
	input  logic                      iPllLock,
	// Pad control
	output logic [pGpioWidth-1:0]     oGpioOutCtrl,
	output logic [pGpioWidth-1:0]     oGpioDir,
	output logic [pGpioWidth-1:0]     oGpioAltMode,
	output logic [cVideoOeWidth-1:0]  oVideoGpioOe,
	output logic [cAudioOeWidth-1:0]  oAudioGpioOe,
	output logic [cRomOeWidth-1:0]    oRomGpioOe,
	output logic [cCfgRomOeWidth-1:0] oCfgRomGpioOe
);

	logic [pExtSwNum-1:0]  wSwSync;
	logic [pGpioWidth-1:0] wGpioInSync;
	logic [pExtSwNum-1:0]  wPushSw;
	logic [pExtSwNum-1:0]  wEdgeSw;
	logic [pExtSwNum-1:0]  wLongSw;
	logic                  wEdgeClr;

	// ------------------------------------------------------------------
	// Pin synchronizer
	// ------------------------------------------------------------------
	SwInputSync #(
		.pExtSwNum  (pExtSwNum),
		.pGpioWidth (pGpioWidth)
	) uSwInputSync (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.iSwRaw      (iSwRaw),
		.iGpioIn     (iGpioIn),
		.oSwSync     (wSwSync),
		.oGpioInSync (wGpioInSync)
	);

	// One filter per push switch
	for (genvar i = 0; i < pExtSwNum; i++)
	begin : gFilter
		SwitchFilter #(
			.pDebounceCycles (pDebounceCycles),
			.pLongCycles     (pLongCycles)
		) uSwitchFilter (
			.iSCLK    (iSCLK),
			.iSRST    (iSRST),
			.iSw      (wSwSync[i]),
			.iEdgeClr (wEdgeClr),
			.oPushSw  (wPushSw[i]),
			.oEdgeSw  (wEdgeSw[i]),
			.oLongSw  (wLongSw[i])
		);
	end

	// ------------------------------------------------------------------
	// Register file
	// ------------------------------------------------------------------
	GpioCsr #(
		.pBlockAdrsWidth (pBlockAdrsWidth),
		.pAdrsMap        (pAdrsMap),
		.pGpioWidth      (pGpioWidth),
		.pExtSwNum       (pExtSwNum)
	) uGpioCsr (
		.iSCLK         (iSCLK),
		.iSRST         (iSRST),
		.iSUsiAdrs     (iSUsiAdrs),
		.iSUsiWd       (iSUsiWd),
		.oSUsiRd       (oSUsiRd),
		.iGpioIn       (wGpioInSync),
		.iPushSw       (wPushSw),
		.iEdgeSw       (wEdgeSw),
		.iLongSw       (wLongSw),
		.iPllLock      (iPllLock),
		.oEdgeClr      (wEdgeClr),
		.oGpioOutCtrl  (oGpioOutCtrl),
		.oGpioDir      (oGpioDir),
		.oGpioAltMode  (oGpioAltMode),
		.oVideoGpioOe  (oVideoGpioOe),
		.oAudioGpioOe  (oAudioGpioOe),
		.oRomGpioOe    (oRomGpioOe),
		.oCfgRomGpioOe (oCfgRomGpioOe)
	);

endmodule

// ==== source/SwInputSync.sv ====
// Two-stage synchronizer for the external switch and GPIO input pins
module SwInputSync #(
	parameter int pExtSwNum  = 7,
	parameter int pGpioWidth = 5
)(
	input  logic                  iSCLK,
	input  logic                  iSRST,
	input  logic [pExtSwNum-1:0]  iSwRaw,
	input  logic [pGpioWidth-1:0] iGpioIn,
	output logic [pExtSwNum-1:0]  oSwSync,
	output logic [pGpioWidth-1:0] oGpioInSync
);

	localparam int cSyncWidth = pExtSwNum + pGpioWidth;

	// Switches and pins share one flop chain
	logic [cSyncWidth-1:0] qRaw;
	logic [cSyncWidth-1:0] rMeta;
	logic [cSyncWidth-1:0] rSync;

	assign qRaw = {iSwRaw, iGpioIn};

	// ------------------------------------------------------------------
	// First stage may go metastable, second one settles it
	// ------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rMeta <= '0;
			rSync <= '0;
		end
		else
		begin
			rMeta <= qRaw;
			rSync <= rMeta;
		end
	end

	// Split back into the two buses
	assign oSwSync     = rSync[cSyncWidth-1:pGpioWidth];
	assign oGpioInSync = rSync[pGpioWidth-1:0];

endmodule

// ==== source/SwitchFilter.sv ====
// Push switch filter with debounce, sticky press flag and long-press level
module SwitchFilter import GpioPkg::*; #(
	parameter int pDebounceCycles = 20000,
	parameter int pLongCycles     = 2000000
)(
	input  logic iSCLK,
	input  logic iSRST,
	input  logic iSw,
	input  logic iEdgeClr,
	output logic oPushSw,
	output logic oEdgeSw,
	output logic oLongSw
);

	// Counter covers both the debounce and the long-press span
	localparam int cCntMax   = (pLongCycles > pDebounceCycles) ? pLongCycles : pDebounceCycles;
	localparam int cCntWidth = $clog2(cCntMax + 1);

	localparam logic [cCntWidth-1:0] cDebounceLast = cCntWidth'(pDebounceCycles - 1);
	localparam logic [cCntWidth-1:0] cLongLast     = cCntWidth'(pLongCycles - 1);

	SwState               rState;
	logic [cCntWidth-1:0] rCnt;

	// ------------------------------------------------------------------
	// Filter FSM
	// oPushSw is the accepted level, SwSettle counts samples unlike it
	// ------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rState  <= SwIdle;
			rCnt    <= '0;
			oPushSw <= 1'b0;
			oEdgeSw <= 1'b0;
			oLongSw <= 1'b0;
		end
		else
		begin
			// Read clear, a press accepted below overrides it
			if (iEdgeClr)
				oEdgeSw <= 1'b0;

			case (rState)
				SwIdle:
				begin
					if (iSw)
					begin
						rState <= SwSettle;
						rCnt   <= cCntWidth'(1);
					end
				end

				SwSettle:
				begin
					if (iSw == oPushSw)
					begin
						// Bounce, fall back to the accepted level
						rCnt <= '0;
						if (!oPushSw)
							rState <= SwIdle;
						else if (oLongSw)
							rState <= SwHeld;
						else
							rState <= SwPressed;
					end
					else if (rCnt == cDebounceLast)
					begin
						rCnt    <= '0;
						oPushSw <= iSw;
						if (iSw)
						begin
							rState  <= SwPressed;
							oEdgeSw <= 1'b1;
						end
						else
						begin
							rState  <= SwIdle;
							oLongSw <= 1'b0;
						end
					end
					else
						rCnt <= rCnt + 1'b1;
				end

				SwPressed:
				begin
					if (!iSw)
					begin
						rState <= SwSettle;
						rCnt   <= cCntWidth'(1);
					end
					else if (rCnt == cLongLast)
					begin
						rState  <= SwHeld;
						rCnt    <= '0;
						oLongSw <= 1'b1;
					end
					else
						rCnt <= rCnt + 1'b1;
				end

				SwHeld:
				begin
					// Long level holds until the release is accepted
					if (!iSw)
					begin
						rState <= SwSettle;
						rCnt   <= cCntWidth'(1);
					end
				end

				default:
				begin
					rState <= SwIdle;
					rCnt   <= '0;
				end
			endcase
		end
	end

endmodule

// ==== source/UsiPkg.sv ====
// USI slave bus definitions shared by the bus slaves and their drivers
package UsiPkg;

	// ------------------------------------------------------------------
	// Bus field layout
	// ------------------------------------------------------------------

	// Word width of address, write data and read data
	localparam int cUsiBusWidth = 32;

	// Address bit that marks the access as a write
	localparam int cUsiWrBit = 30;

	// Block select field starts here, its width is set per slave
	localparam int cBlockLsb = 16;

	// Register offset inside a block, low address bits
	localparam int cCsrOffsetWidth = 8;

	// ------------------------------------------------------------------
	// Access kind, taken from the write bit
	// ------------------------------------------------------------------
	typedef enum logic
	{
		UsiRead  = 1'b0,
		UsiWrite = 1'b1
	} UsiAccess;

endpackage

// ==== test/GpioSubsystemTb.sv ====
// Directed testbench for the GPIO subsystem bus registers, status and switch filters
module GpioSubsystemTb import UsiPkg::*; import GpioPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [7:0]  cBlock    = 8'd1;
	localparam logic [31:0] cIdleAdrs = 32'h0000_00FF;
	localparam logic [7:0]  cWrOffsets[7] = '{8'h00, 8'h04, 8'h08, 8'h10, 8'h14, 8'h18, 8'h1C};
	localparam int          cWrWidths[7]  = '{5, 5, 5, 24, 3, 8, 7};
	localparam string       cWrNames[7]   = '{"oGpioOutCtrl", "oGpioDir", "oGpioAltMode",
		"oVideoGpioOe", "oAudioGpioOe", "oRomGpioOe", "oCfgRomGpioOe"};

	logic        iSCLK = 1'b0;
	logic        iSRST;
	logic [31:0] iSUsiAdrs;
	logic [31:0] iSUsiWd;
	logic [31:0] oSUsiRd;
	logic [4:0]  iGpioIn;
	logic [6:0]  iSwRaw;
	logic        iPllLock;
	logic [4:0]  oGpioOutCtrl;
	logic [4:0]  oGpioDir;
	logic [4:0]  oGpioAltMode;
	logic [23:0] oVideoGpioOe;
	logic [2:0]  oAudioGpioOe;
	logic [7:0]  oRomGpioOe;
	logic [6:0]  oCfgRomGpioOe;
	int          checkCount = 0;
	int          errCount = 0;

	GpioSubsystem #(.pDebounceCycles (8), .pLongCycles (64)) i_dut (.*);

	always #2 iSCLK = ~iSCLK;

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errCount++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		$display("%s: %0d errors", name, errCount - errBefore);
	endtask

	// ------------------------------------------------------------------
	// Bus accesses, called on a falling edge
	// ------------------------------------------------------------------
	task automatic busWrite(input logic [7:0] offset, input logic [31:0] data,
		input logic [7:0] block);
		iSUsiAdrs = (32'(UsiWrite) << cUsiWrBit) | (32'(block) << cBlockLsb) | 32'(offset);
		iSUsiWd   = data;
		@(negedge iSCLK);
		iSUsiAdrs = cIdleAdrs;
	endtask

	task automatic busRead(input logic [7:0] offset, input logic [31:0] data,
		output logic [31:0] rd);
		iSUsiAdrs = (32'(UsiRead) << cUsiWrBit) | (32'(cBlock) << cBlockLsb) | 32'(offset);
		iSUsiWd   = data;
		@(negedge iSCLK);
		rd        = oSUsiRd;
		iSUsiAdrs = cIdleAdrs;
	endtask

	// Poll a status bit, 100 reads at most
	task automatic waitForBit(input logic [7:0] offset, input int idx, input logic value);
		logic [31:0] rd;
		int          n;
		n = 0;
		busRead(offset, '0, rd);
		while (rd[idx] !== value && n < 100)
		begin
			busRead(offset, '0, rd);
			n++;
		end
		if (rd[idx] !== value)
		begin
			errCount++;
			$display("Timeout: offset %h bit %0d never became %0b", offset, idx, value);
		end
	endtask

	function automatic logic [31:0] portValue(input int k);
		case (k)
			0: return 32'(oGpioOutCtrl);
			1: return 32'(oGpioDir);
			2: return 32'(oGpioAltMode);
			3: return 32'(oVideoGpioOe);
			4: return 32'(oAudioGpioOe);
			5: return 32'(oRomGpioOe);
			default: return 32'(oCfgRomGpioOe);
		endcase
	endfunction

	// ------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------
	task automatic testResetDefaults();
		int          errBefore;
		logic [31:0] rd;
		logic [31:0] exp;
		errBefore = errCount;
		for (int k = 0; k < 7; k++)
		begin
			// Direction and alternate mode come up all ones
			exp = (k == 1 || k == 2) ? 32'h1F : 32'h0;
			checkValue(cWrNames[k], portValue(k), exp);
			busRead(cWrOffsets[k], '0, rd);
			checkValue({"oSUsiRd for ", cWrNames[k]}, rd, exp);
		end
		reportTest("testResetDefaults", errBefore);
	endtask

	task automatic testRegisterAccess();
		int          errBefore;
		logic [31:0] data;
		logic [31:0] exp;
		logic [31:0] outCtrlExp;
		logic [31:0] rd;
		errBefore  = errCount;
		outCtrlExp = '0;
		for (int k = 0; k < 7; k++)
		begin
			data = $urandom();
			exp  = data & ((32'd1 << cWrWidths[k]) - 1);
			if (k == 0)
				outCtrlExp = exp;
			busWrite(cWrOffsets[k], data, cBlock);
			checkValue(cWrNames[k], portValue(k), exp);
			busRead(cWrOffsets[k], '0, rd);
			checkValue({"oSUsiRd for ", cWrNames[k]}, rd, exp);
		end
		// Foreign block number
		busWrite(RegOutCtrl, ~outCtrlExp, cBlock + 8'd1);
		checkValue("oGpioOutCtrl after foreign write", portValue(0), outCtrlExp);
		reportTest("testRegisterAccess", errBefore);
	endtask

	task automatic testStatusReads();
		int          errBefore;
		logic [31:0] data;
		logic [31:0] rd;
		errBefore = errCount;
		data = $urandom();
		busRead(8'h80, data, rd);
		checkValue("oSUsiRd for unmapped offset", rd, data);
		iGpioIn = 5'($urandom());
		repeat (3) @(negedge iSCLK);
		busRead(RegGpioIn, '0, rd);
		checkValue("oSUsiRd for RegGpioIn", rd, 32'(iGpioIn));
		iPllLock = 1'b1;
		busRead(RegPllLock, '0, rd);
		checkValue("oSUsiRd for RegPllLock", rd, 32'h1);
		iPllLock = 1'b0;
		busRead(RegPllLock, '0, rd);
		checkValue("oSUsiRd for RegPllLock", rd, 32'h0);
		reportTest("testStatusReads", errBefore);
	endtask

	task automatic testDebounce();
		int          errBefore;
		logic [31:0] rd;
		errBefore = errCount;
		// Two cycles high, two low
		for (int n = 0; n < 6; n++)
		begin
			iSwRaw[0] = 1'b1;
			busRead(RegPushSw, '0, rd);
			checkValue("oSUsiRd for RegPushSw while bouncing", rd, 32'h0);
			@(negedge iSCLK);
			iSwRaw[0] = 1'b0;
			busRead(RegPushSw, '0, rd);
			checkValue("oSUsiRd for RegPushSw while bouncing", rd, 32'h0);
			@(negedge iSCLK);
		end
		repeat (12) @(negedge iSCLK);
		busRead(RegEdgeSw, '0, rd);
		checkValue("oSUsiRd for RegEdgeSw after bouncing", rd, 32'h0);
		iSwRaw[0] = 1'b1;
		waitForBit(RegPushSw, 0, 1'b1);
		busRead(RegPushSw, '0, rd);
		checkValue("oSUsiRd for RegPushSw when pressed", rd, 32'h1);
		iSwRaw[0] = 1'b0;
		waitForBit(RegPushSw, 0, 1'b0);
		reportTest("testDebounce", errBefore);
	endtask

	task automatic testStickyFlag();
		int          errBefore;
		logic [31:0] rd;
		errBefore = errCount;
		// Drop any flag left from earlier presses
		busRead(RegEdgeSw, '0, rd);
		iSwRaw[1] = 1'b1;
		waitForBit(RegPushSw, 1, 1'b1);
		iSwRaw[1] = 1'b0;
		waitForBit(RegPushSw, 1, 1'b0);
		busRead(RegEdgeSw, '0, rd);
		checkValue("oSUsiRd for RegEdgeSw first read", rd, 32'h2);
		busRead(RegEdgeSw, '0, rd);
		checkValue("oSUsiRd for RegEdgeSw second read", rd, 32'h0);
		reportTest("testStickyFlag", errBefore);
	endtask

	task automatic testLongPress();
		int          errBefore;
		logic [31:0] rd;
		errBefore = errCount;
		iSwRaw[2] = 1'b1;
		waitForBit(RegLongSw, 2, 1'b1);
		iSwRaw[2] = 1'b0;
		waitForBit(RegPushSw, 2, 1'b0);
		busRead(RegLongSw, '0, rd);
		checkValue("oSUsiRd for RegLongSw after release", rd, 32'h0);
		// Short press of about 30 cycles
		iSwRaw[3] = 1'b1;
		for (int n = 0; n < 29; n++)
		begin
			busRead(RegLongSw, '0, rd);
			checkValue("oSUsiRd for RegLongSw on short press", rd, 32'h0);
		end
		busRead(RegPushSw, '0, rd);
		checkValue("oSUsiRd for RegPushSw on short press", rd, 32'h8);
		iSwRaw[3] = 1'b0;
		waitForBit(RegPushSw, 3, 1'b0);
		busRead(RegLongSw, '0, rd);
		checkValue("oSUsiRd for RegLongSw after short press", rd, 32'h0);
		reportTest("testLongPress", errBefore);
	endtask

	initial
	begin
		void'($urandom(65870));
		iSRST     = 1'b1;
		iSUsiAdrs = cIdleAdrs;
		iSUsiWd   = '0;
		iGpioIn   = '0;
		iSwRaw    = '0;
		iPllLock  = 1'b0;
		repeat (16) @(negedge iSCLK);
		iSRST = 1'b0;
		@(negedge iSCLK);
		testResetDefaults();
		testRegisterAccess();
		testStatusReads();
		testDebounce();
		testStickyFlag();
		testLongPress();
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== test/GpioSubsystem_props.sv ====
// Concurrent checks on GPIO subsystem reset values, write timing and read-clear strobe
module GpioSubsystemProps import UsiPkg::*; import GpioPkg::*; #(
	parameter int                         pBlockAdrsWidth = 8,
	parameter logic [pBlockAdrsWidth-1:0] pAdrsMap        = 1,
	parameter int                         pGpioWidth      = 5,
	parameter int                         pExtSwNum       = 7
)(
	input logic                      iSCLK,
	input logic                      iSRST,
	input logic [cUsiBusWidth-1:0]   iSUsiAdrs,
	input logic [cUsiBusWidth-1:0]   iSUsiWd,
	input logic [cUsiBusWidth-1:0]   oSUsiRd,
	input logic                      iEdgeClr,
	input logic [pExtSwNum-1:0]      iEdgeSw,
	input logic [pGpioWidth-1:0]     oGpioOutCtrl,
	input logic [pGpioWidth-1:0]     oGpioDir,
	input logic [pGpioWidth-1:0]     oGpioAltMode,
	input logic [cVideoOeWidth-1:0]  oVideoGpioOe,
	input logic [cAudioOeWidth-1:0]  oAudioGpioOe,
	input logic [cRomOeWidth-1:0]    oRomGpioOe,
	input logic [cCfgRomOeWidth-1:0] oCfgRomGpioOe
);

	timeunit 1ns;
	timeprecision 100ps;

	// Outputs one cycle after a reset edge
	assert property (@(posedge iSCLK) iSRST |=> (oGpioOutCtrl == '0 && oGpioDir == '1
		&& oGpioAltMode == '1 && oVideoGpioOe == '0 && oAudioGpioOe == '0
		&& oRomGpioOe == '0 && oCfgRomGpioOe == '0 && oSUsiRd == '0))
	else
		$error("Control outputs not at reset values after reset");

	// Direction write lands one cycle later
	assert property (@(posedge iSCLK) disable iff (iSRST)
		(iSUsiAdrs[cUsiWrBit] && iSUsiAdrs[cBlockLsb +: pBlockAdrsWidth] == pAdrsMap
		&& iSUsiAdrs[cCsrOffsetWidth-1:0] == RegDir)
		|=> (oGpioDir == $past(iSUsiWd[pGpioWidth-1:0])))
	else
		$error("Write to direction register not seen on oGpioDir");

	// Press flags fall only after the clear strobe of a RegEdgeSw read
	assert property (@(posedge iSCLK) disable iff (iSRST)
		(|($past(iEdgeSw) & ~iEdgeSw)) |-> $past(iEdgeClr && !iSUsiAdrs[cUsiWrBit]
		&& iSUsiAdrs[cCsrOffsetWidth-1:0] == RegEdgeSw))
	else
		$error("Press flag dropped without a read of the press flags");

endmodule

bind GpioSubsystem GpioSubsystemProps #(
	.pBlockAdrsWidth (pBlockAdrsWidth),
	.pAdrsMap        (pAdrsMap),
	.pGpioWidth      (pGpioWidth),
	.pExtSwNum       (pExtSwNum)
) uProps (
	.*,
	.iEdgeClr (wEdgeClr),
	.iEdgeSw  (wEdgeSw)
);
